// ==== hdl/fetch_settings.svh ====
////////////////////
// fetch front end build constants.
// boot address, instruction ROM size and ROM response latency.
////////////////////

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// program counter value after reset, must be word aligned.
`define FETCH_BOOT_ADDR 32'h0000_0100

// ROM word-address width, 8 bits gives 256 words.
`define FETCH_ROM_AW 8

// cycles from a sampled req to a raised ack, at least 1.
`define FETCH_ROM_LAT 2

`endif

// ==== hdl/fetch_pkg.sv ====
////////////////////
// fetch front end types.
// opcode classes, controller states and the bundles between blocks.
////////////////////

package fetch_pkg;

    // opcode classes, encoded with the RV32I major opcode so a compare is direct.
    typedef enum logic [6:0] {
        op_other  = 7'b0000000, // anything that does not change the flow.
        op_branch = 7'b1100011, // conditional branch, B-type.
        op_jal    = 7'b1101111, // jump and link, J-type.
        op_jalr   = 7'b1100111  // register jump, target only known in execute.
    } inst_op_e;

    // fetch controller states.
    typedef enum logic [2:0] {
        st_idle,    // out of reset, first read goes out next edge.
        st_req,     // req is high, waiting for ack.
        st_release, // req dropped, waiting for ack to fall.
        st_hold,    // bus idle, output buffer still full.
        st_stop     // jalr seen, no fetch until a redirect.
    } fetch_state_e;

    // one instruction handed to the consumer.
    typedef struct packed {
        logic [31:0] pc;         // address the word was read from.
        logic [31:0] inst;       // raw instruction word.
        logic        pred_taken; // backward branch or jal.
    } fetch_bundle_t;

    // static prediction for the word on the memory data bus.
    typedef struct packed {
        inst_op_e    op;     // opcode class.
        logic        take;   // follow target instead of pc + 4.
        logic        stop;   // jalr, stall until execute answers.
        logic [31:0] target; // pc plus the B or J immediate.
    } predecode_t;

    // flow change from execute, en is a single-cycle pulse.
    typedef struct packed {
        logic        en;
        logic [31:0] pc;
    } redirect_t;

endpackage

// ==== hdl/branch_predecode.sv ====
////////////////////
// static branch predecoder.
// classifies a fetched word and forms its predicted next address.
////////////////////

`timescale 1ns/10ps

module branch_predecode import fetch_pkg::*; (
    input  logic [31:0] pc,   // address of the word being decoded.
    input  logic [31:0] inst, // word straight off the memory bus.
    output predecode_t  pd    // prediction, valid in the same cycle.
);

    inst_op_e    op;    // opcode class of inst.
    logic [31:0] b_imm; // sign extended B-type offset.
    logic [31:0] j_imm; // sign extended J-type offset.
    logic [31:0] imm;   // offset picked by class.

    ////////////////////
    // opcode class
    ////////////////////

    // only the major opcode matters here, funct3 is left to decode.
    always_comb begin
        case (inst[6:0])
            op_branch: op = op_branch;
            op_jal:    op = op_jal;
            op_jalr:   op = op_jalr;
            default:   op = op_other;
        endcase
    end

    ////////////////////
    // immediates
    ////////////////////

    // B-type keeps imm[12|10:5] in the top bits and imm[4:1|11] next to rd.
    assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    // J-type scatters imm[20|10:1|11|19:12] over the upper twenty bits.
    assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign imm = (op == op_jal) ? j_imm : b_imm; // jalr and others ignore it.

    ////////////////////
    // prediction
    ////////////////////

    always_comb begin
        pd.op     = op;
        pd.target = pc + imm; // meaningful for branches and jal only.

        // a backward branch is usually a loop, so it is taken.
        // inst[31] is the immediate sign bit for both B and J formats.
        pd.take = (op == op_jal) || ((op == op_branch) && inst[31]);

        // the jalr target depends on a register value.
        // fetch has to wait for execute to send it.
        pd.stop = (op == op_jalr);
    end

endmodule

// ==== hdl/fetch_ctrl.sv ====
////////////////////
// fetch controller.
// pc, four-phase memory master, one-entry output buffer and redirects.
////////////////////

`timescale 1ns/10ps

`include "fetch_settings.svh"

module fetch_ctrl import fetch_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    output logic          mem_req,    // four-phase request to the ROM.
    output logic [31:0]   mem_addr,   // stable while mem_req is high.
    input  logic          mem_ack,
    input  logic [31:0]   mem_data,   // valid while mem_ack is high.
    output logic [31:0]   pd_pc,      // word address to the predecoder.
    output logic [31:0]   pd_inst,    // word to the predecoder.
    input  predecode_t    pd,
    input  redirect_t     redirect,   // single-cycle flow change from execute.
    output logic          out_valid,
    output fetch_bundle_t out_bundle,
    input  logic          out_ready
);

    fetch_state_e state;     // controller state.
    logic [31:0]  pc;        // address of the next read to launch.
    logic         discard;   // open read was overtaken by a redirect.
    logic         buf_free;  // output buffer can take a new word soon.
    logic         launch;    // raise req this edge.
    logic         ack_use;   // returning word goes to the consumer.
    logic [31:0]  launch_pc; // address of a read started this edge.
    logic [31:0]  next_pc;   // predicted address after the returning word.

    ////////////////////
    // datapath helpers
    ////////////////////

    assign pd_pc   = mem_addr; // the open read's address is the word's pc.
    assign pd_inst = mem_data;

    // a redirect empties the buffer at this edge, so it counts as free.
    assign buf_free  = !out_valid || out_ready || redirect.en;
    assign launch_pc = redirect.en ? redirect.pc : pc;
    assign next_pc   = pd.take ? pd.target : mem_addr + 32'd4;

    // a word is kept only if no redirect touched its read.
    assign ack_use = (state == st_req) && mem_ack && !discard && !redirect.en;

    // a new read needs ack low first and somewhere for the word to go.
    always_comb begin
        case (state)
            st_idle:             launch = 1'b1; // ack and buffer are clear after reset.
            st_release, st_hold: launch = !mem_ack && buf_free;
            st_stop:             launch = redirect.en && !mem_ack;
            default:             launch = 1'b0;
        endcase
    end

    ////////////////////
    // state machine
    ////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= st_idle;
            mem_req <= 1'b0;
            pc      <= `FETCH_BOOT_ADDR;
            discard <= 1'b0;
        end else begin
            case (state)
                st_req: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0; // second phase, let go of the bus.
                        discard <= 1'b0;
                        if (redirect.en) begin
                            pc <= redirect.pc;
                        end else if (!discard) begin
                            pc <= next_pc; // a discarded read keeps the redirect pc.
                        end
                        state <= (ack_use && pd.stop) ? st_stop : st_release;
                    end else if (redirect.en) begin
                        // the read cannot be aborted on the wire.
                        // its word is dropped when ack comes back.
                        pc      <= redirect.pc;
                        discard <= 1'b1;
                    end
                end
                st_release, st_hold, st_stop: begin
                    if (launch) begin
                        mem_req <= 1'b1;
                        pc      <= launch_pc;
                        state   <= st_req;
                    end else begin
                        if (redirect.en) begin
                            pc <= redirect.pc;
                        end
                        if (state == st_stop) begin
                            if (redirect.en) begin
                                state <= st_release; // ack still high, wait it out.
                            end
                        end else if (!mem_ack) begin
                            state <= st_hold; // bus is idle, consumer is not.
                        end
                    end
                end
                default: begin // st_idle
                    mem_req <= 1'b1;
                    pc      <= launch_pc;
                    state   <= st_req;
                end
            endcase
        end
    end

    ////////////////////
    // output buffer
    ////////////////////

    // a redirect wins over a handshake at the same edge.
    // the consumer must not count a bundle on that edge.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else if (redirect.en) begin
            out_valid <= 1'b0;
        end else if (ack_use) begin
            out_valid <= 1'b1; // the buffer is always empty when ack returns.
        end else if (out_valid && out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // the read address is latched when a read is launched.
    // the bundle is captured from the word that comes back.
    always_ff @(posedge clk) begin
        if (launch) begin
            mem_addr <= launch_pc;
        end
        if (ack_use) begin
            out_bundle.pc         <= mem_addr;
            out_bundle.inst       <= mem_data;
            out_bundle.pred_taken <= pd.take;
        end
    end

endmodule

// ==== hdl/imem_rom.sv ====
////////////////////
// instruction ROM.
// answers a four-phase req/ack after a fixed latency, loadable from outside.
////////////////////

`timescale 1ns/10ps

`include "fetch_settings.svh"

module imem_rom (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mem_req,   // held high until ack.
    input  logic [31:0]              mem_addr,  // byte address, low two bits ignored.
    output logic                     mem_ack,
    output logic [31:0]              mem_data,  // valid while mem_ack is high.
    input  logic                     load_en,   // program load write strobe.
    input  logic [`FETCH_ROM_AW-1:0] load_addr, // word address for the load.
    input  logic [31:0]              load_data
);

    localparam int DEPTH = 1 << `FETCH_ROM_AW; // words in the array.
    localparam int LAT   = `FETCH_ROM_LAT;     // req seen to ack raised.
    localparam int CW    = (LAT > 1) ? $clog2(LAT) : 1;

    logic [31:0]              mem [DEPTH]; // program storage.
    logic [CW-1:0]            lat_cnt;     // edges spent on the current req.
    logic [`FETCH_ROM_AW-1:0] rd_idx;      // word index of the read.
    logic                     fire;        // latency is up, answer now.

    // addresses past the array wrap around.
    assign rd_idx = mem_addr[`FETCH_ROM_AW+1:2];

    // the first edge that sees req counts as one.
    // with LAT of 1 the answer comes right away.
    assign fire = mem_req && !mem_ack && (lat_cnt == CW'(LAT - 1));

    ////////////////////
    // handshake
    ////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mem_ack <= 1'b0;
            lat_cnt <= '0;
        end else if (mem_ack) begin
            if (!mem_req) begin
                mem_ack <= 1'b0; // fourth phase, back to idle.
            end
        end else if (mem_req) begin
            if (fire) begin
                mem_ack <= 1'b1;
                lat_cnt <= '0; // ready for the next request.
            end else begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    ////////////////////
    // storage
    ////////////////////

    // the load port is only used while the core is held in reset.
    // nothing stops it from writing later.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        if (fire) begin
            mem_data <= mem[rd_idx]; // held until the next read answers.
        end
    end

endmodule

// ==== hdl/fetch_top.sv ====
////////////////////
// fetch front end top.
// controller, predecoder and instruction ROM wired together.
////////////////////

`timescale 1ns/10ps

`include "fetch_settings.svh"

module fetch_top import fetch_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  redirect_t                redirect,   // from execute.
    output logic                     out_valid,  // bundle offered to the consumer.
    output fetch_bundle_t            out_bundle,
    input  logic                     out_ready,
    input  logic                     load_en,    // ROM program load.
    input  logic [`FETCH_ROM_AW-1:0] load_addr,
    input  logic [31:0]              load_data
);

    logic        mem_req;  // controller to ROM.
    logic [31:0] mem_addr;
    logic        mem_ack;  // ROM to controller.
    logic [31:0] mem_data;
    logic [31:0] pd_pc;    // word under predecode.
    logic [31:0] pd_inst;
    predecode_t  pd;       // prediction back to the controller.

    fetch_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ack    (mem_ack),
        .mem_data   (mem_data),
        .pd_pc      (pd_pc),
        .pd_inst    (pd_inst),
        .pd         (pd),
        .redirect   (redirect),
        .out_valid  (out_valid),
        .out_bundle (out_bundle),
        .out_ready  (out_ready)
    );

    branch_predecode i_predecode (
        .pc   (pd_pc),
        .inst (pd_inst),
        .pd   (pd)
    );

    imem_rom i_rom (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_data  (mem_data),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// ==== tests/fetch_props.sv ====
////////////////////
// fetch controller properties.
// memory handshake order and output back-pressure rules.
////////////////////

`timescale 1ns/10ps

module fetch_props import fetch_pkg::*; (
    input logic          clk,
    input logic          rst,
    input logic          mem_req,
    input logic          mem_ack,
    input logic          out_valid,
    input logic          out_ready,
    input fetch_bundle_t out_bundle
);

    int fail_cnt = 0; // number of failed assertions.

    // the request stays up until the ROM answers.
    req_held: assert property (@(posedge clk) disable iff (!rst)
        mem_req && !mem_ack |=> mem_req)
        else begin
            fail_cnt++;
            $error("mem_req dropped before mem_ack");
        end

    // the ROM only answers a request it has seen.
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
        $rose(mem_ack) |-> $past(mem_req))
        else begin
            fail_cnt++;
            $error("mem_ack rose without mem_req");
        end

    // a new request waits for the previous ack to fall.
    req_after_ack: assert property (@(posedge clk) disable iff (!rst)
        $rose(mem_req) |-> !$past(mem_ack))
        else begin
            fail_cnt++;
            $error("mem_req rose while mem_ack was high");
        end

    // a stalled bundle keeps its value, a redirect may still drop it.
    bundle_stable: assert property (@(posedge clk) disable iff (!rst)
        out_valid && !out_ready |=> !out_valid || $stable(out_bundle))
        else begin
            fail_cnt++;
            $error("out_bundle changed under back-pressure");
        end

    // nothing is offered straight out of reset.
    valid_reset: assert property (@(posedge clk) $rose(rst) |-> !out_valid)
        else begin
            fail_cnt++;
            $error("out_valid high after reset");
        end

endmodule

bind fetch_ctrl fetch_props i_props (
    .clk        (clk),
    .rst        (rst),
    .mem_req    (mem_req),
    .mem_ack    (mem_ack),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_bundle (out_bundle)
);

// ==== tests/fetch_tb.sv ====
////////////////////
// fetch front end testbench.
// random program, execute-stage model and reference check of every bundle.
////////////////////

`timescale 1ns/10ps

`include "fetch_settings.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int DEPTH     = 1 << `FETCH_ROM_AW; // ROM words.
    localparam int STALL_WIN = 12;                 // quiet cycles expected after a jalr.

    logic                     clk = 1'b0;
    logic                     rst;
    redirect_t                redirect;
    logic                     out_valid;
    fetch_bundle_t            out_bundle;
    logic                     out_ready;
    logic                     load_en;
    logic [`FETCH_ROM_AW-1:0] load_addr;
    logic [31:0]              load_data;

    integer      seed = 32'ha6df;   // fixed seed for $random.
    logic [31:0] prog [DEPTH];      // testbench copy of the program.
    inst_op_e    prog_op [DEPTH];   // class of each word, known from generation.
    int          prog_off [DEPTH];  // branch or jal byte offset.
    logic [31:0] exp_pc;            // pc of the next bundle the model expects.
    int          stall_cnt = 0;     // cycles left in a jalr wait.
    int          errors = 0;
    int          tests = 0;
    int          failed = 0;
    int          n_got, n_taken, n_jalr;

    fetch_top i_dut (.*);

    always #5 clk = ~clk; // 10 ns period.

    ////////////////////
    // helpers
    ////////////////////

    task automatic bundle_compare(input fetch_bundle_t got, input fetch_bundle_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL out_bundle got %h expected %h (pc %h)", got, exp, exp.pc);
        end
    endtask

    task automatic word_compare(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // random word aligned address inside the ROM.
    function automatic logic [31:0] random_pc();
        logic [31:0] v;
        v = $random(seed);
        return {{(30 - `FETCH_ROM_AW){1'b0}}, v[`FETCH_ROM_AW-1:0], 2'b00};
    endfunction

    // builds one instruction and records what it is, so no decode is needed later.
    function automatic void make_inst(input int i);
        logic [31:0] v;
        logic [31:0] r;
        logic [20:0] o;
        int          off;
        v = $random(seed); // class and offset.
        r = $random(seed); // register and funct fields.
        prog_off[i] = 0;
        case (v[3:0])
            4'd8, 4'd9, 4'd10, 4'd11: begin
                off = 4 * (1 + int'(v[6:4])); // short loop or skip.
                if (v[3:0] >= 4'd10) off = -off;
                o = off;
                prog[i] = {o[12], o[10:5], r[24:12], o[4:1], o[11], 7'b1100011};
                prog_op[i] = op_branch;
                prog_off[i] = off;
            end
            4'd12, 4'd13: begin
                off = 4 * (1 + int'(v[9:4]));
                if (v[10]) off = -off;
                o = off;
                prog[i] = {o[20], o[10:1], o[11], o[19:12], r[11:7], 7'b1101111};
                prog_op[i] = op_jal;
                prog_off[i] = off;
            end
            4'd14: begin
                prog[i] = {r[31:15], 3'b000, r[11:7], 7'b1100111};
                prog_op[i] = op_jalr;
            end
            default: begin // plain ALU work.
                prog[i] = {r[31:7], v[8] ? 7'b0010011 : 7'b0110011};
                prog_op[i] = op_other;
            end
        endcase
    endfunction

    // one clock, sample at the falling edge, drive 1 ns after the rising edge.
    task automatic cycle_step(input bit bp, input bit rnd_redir);
        fetch_bundle_t exp;
        redirect_t     nxt;
        int            idx;
        nxt = '0;
        @(negedge clk);
        if (redirect.en) begin
            exp_pc    = redirect.pc; // buffer and open read are dropped at this edge.
            stall_cnt = 0;
        end else begin
            if (stall_cnt > 0 && out_valid) begin
                errors++;
                $display("bundle at pc %h offered while fetch waits for a jalr target",
                         out_bundle.pc);
            end
            if (out_valid && out_ready) begin
                idx            = exp_pc[`FETCH_ROM_AW+1:2];
                exp.pc         = exp_pc;
                exp.inst       = prog[idx];
                exp.pred_taken = (prog_op[idx] == op_jal) ||
                                 (prog_op[idx] == op_branch && prog_off[idx] < 0);
                bundle_compare(out_bundle, exp);
                n_got++;
                if (exp.pred_taken) begin
                    exp_pc = exp_pc + prog_off[idx];
                    n_taken++;
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
                if (prog_op[idx] == op_jalr) begin
                    stall_cnt = STALL_WIN; // execute answers after a while.
                    n_jalr++;
                end else if (prog_op[idx] == op_branch && prog_off[idx] < 0 &&
                             ($random(seed) & 3) == 0) begin
                    nxt.en = 1'b1; // execute found the loop branch not taken.
                    nxt.pc = exp.pc + 32'd4;
                end
            end
            if (stall_cnt > 0) begin
                stall_cnt--;
                if (stall_cnt == 0) begin
                    nxt.en = 1'b1; // jalr target resolved.
                    nxt.pc = random_pc();
                end
            end
            if (rnd_redir && ($random(seed) & 15) == 0) begin
                nxt.en = 1'b1;
                nxt.pc = random_pc();
            end
        end
        @(posedge clk);
        #1;
        redirect  = nxt;
        out_ready = bp ? ($random(seed) % 3 != 0) : 1'b1;
    endtask

    // runs until n bundles are delivered or the cycle budget runs out.
    task automatic run_test(input string name, input int n, input bit bp, input bit rr);
        int cyc;
        int e0;
        e0      = errors;
        cyc     = 0;
        n_got   = 0;
        n_taken = 0;
        n_jalr  = 0;
        while (n_got < n && cyc < n * 40) begin
            cycle_step(bp, rr);
            cyc++;
        end
        if (n_got < n) begin
            errors++;
            $display("timeout in test %s, only %0d of %0d bundles arrived", name, n_got, n);
        end
        tests++;
        if (errors != e0) failed++;
        $display("test %-12s %0d bundles, %0d taken, %0d jalr, %0d errors",
                 name, n_got, n_taken, n_jalr, errors - e0);
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        rst       = 1'b0;
        redirect  = '0;
        out_ready = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        for (int i = 0; i < DEPTH; i++) begin
            make_inst(i);
        end
        for (int i = 0; i < DEPTH; i++) begin
            @(posedge clk);
            #1;
            load_en   = 1'b1;
            load_addr = i[`FETCH_ROM_AW-1:0];
            load_data = prog[i];
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
        repeat (4) @(posedge clk);
        word_compare("pc", i_dut.i_ctrl.pc, `FETCH_BOOT_ADDR);
        tests++;
        if (errors != 0) failed++;
        $display("test %-12s %0d errors", "reset", errors);
        #1;
        rst       = 1'b1;
        out_ready = 1'b1;
        exp_pc    = `FETCH_BOOT_ADDR; // first bundle comes from the boot address.

        run_test("straight", 150, 1'b0, 1'b0);
        run_test("backpressure", 200, 1'b1, 1'b0);
        run_test("redirect", 300, 1'b1, 1'b1);

        errors = errors + i_dut.i_ctrl.i_props.fail_cnt;
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/branch_predecode.sv
hdl/fetch_ctrl.sv
hdl/imem_rom.sv
hdl/fetch_top.sv
tests/fetch_props.sv
tests/fetch_tb.sv
